//--- wb_pkg.sv
// peripheral bus widths
// pipelined wishbone request and response structs

package wb_pkg;

    // address and data widths of the peripheral bus
    localparam int unsigned PERIPH_WB_AW = 32;
    localparam int unsigned PERIPH_WB_DW = 32;
    // one select bit per byte lane
    localparam int unsigned PERIPH_WB_SW = PERIPH_WB_DW / 8;

    // master to slave, low two address bits are ignored
    typedef struct packed {
        logic                    cyc;
        logic                    stb;
        logic                    we;
        logic [PERIPH_WB_AW-1:0] addr;
        logic [PERIPH_WB_DW-1:0] wdata;
        logic [PERIPH_WB_SW-1:0] sel;
    } wb_req_t;

    // slave to master
    typedef struct packed {
        logic                    ack;
        logic                    err;
        logic                    stall;
        logic [PERIPH_WB_DW-1:0] rdata;
    } wb_rsp_t;

endpackage: wb_pkg

//--- periph_pkg.sv
// peripheral address map and crossbar slave indices
// timer and led register offsets, reset values
// load command passed from the timer registers to the counter

package periph_pkg;

    // crossbar slots
    localparam int unsigned PERIPH_XBAR_NUM_SLAVES           = 2;
    localparam int unsigned PERIPH_XBAR_MTIMER_SLAVE_IDX     = 0;
    localparam int unsigned PERIPH_XBAR_LED_DRIVER_SLAVE_IDX = 1;

    // every slave owns a 4 KiB window
    localparam int unsigned PERIPH_WINDOW_AW = 12;

    localparam logic [31:0] MTIMER_BASE = 32'h0000_0000;
    localparam logic [31:0] LED_BASE    = 32'h0000_1000;

    // mtimer register offsets
    localparam logic [PERIPH_WINDOW_AW-1:0] MTIMER_MTIME_LO    = 12'h000;
    localparam logic [PERIPH_WINDOW_AW-1:0] MTIMER_MTIME_HI    = 12'h004;
    localparam logic [PERIPH_WINDOW_AW-1:0] MTIMER_MTIMECMP_LO = 12'h008;
    localparam logic [PERIPH_WINDOW_AW-1:0] MTIMER_MTIMECMP_HI = 12'h00C;

    // led driver register offsets
    localparam logic [PERIPH_WINDOW_AW-1:0] LED_STATUS = 12'h000;
    localparam logic [PERIPH_WINDOW_AW-1:0] LED_SET    = 12'h004;
    localparam logic [PERIPH_WINDOW_AW-1:0] LED_CLEAR  = 12'h008;
    localparam logic [PERIPH_WINDOW_AW-1:0] LED_TOGGLE = 12'h00C;

    localparam logic [63:0] MTIME_RESET      = 64'h0;
    localparam logic [63:0] MTIMECMP_RESET   = '1;
    localparam logic [7:0]  LED_STATUS_RESET = 8'h00;

    // word load into the running mtime counter
    typedef struct packed {
        logic        load_lo;
        logic        load_hi;
        logic [31:0] value;
    } mtimer_load_t;

endpackage: periph_pkg

//--- periph_xbar.sv
// peripheral crossbar, one master to the peripheral slaves
// address decode, stb gating, response mux
// single outstanding transfer guard, built-in error responder

module periph_xbar (
    input  logic            clk_i,
    input  logic            rst_n_i,

    input  wb_pkg::wb_req_t master_req_i,
    output wb_pkg::wb_rsp_t master_rsp_o,

    output wb_pkg::wb_req_t slave_req_o [periph_pkg::PERIPH_XBAR_NUM_SLAVES],
    input  wb_pkg::wb_rsp_t slave_rsp_i [periph_pkg::PERIPH_XBAR_NUM_SLAVES]
);
    import wb_pkg::*;
    import periph_pkg::*;

    localparam int unsigned IDX_W = (PERIPH_XBAR_NUM_SLAVES > 1) ?
                                    $clog2(PERIPH_XBAR_NUM_SLAVES) : 1;

    logic [PERIPH_XBAR_NUM_SLAVES-1:0] slave_hit;
    logic [IDX_W-1:0]                  hit_idx;
    logic [IDX_W-1:0]                  sel_q;
    logic                              busy_q;
    logic                              err_q;
    logic                              accept;
    logic                              unmapped;
    logic                              rsp_done;

    // upper address bits must match the window base
    function automatic logic in_window(input logic [PERIPH_WB_AW-1:0] addr,
                                       input logic [31:0] base);
        return addr[PERIPH_WB_AW-1:PERIPH_WINDOW_AW] == base[31:PERIPH_WINDOW_AW];
    endfunction

    always_comb begin
        slave_hit = '0;
        slave_hit[PERIPH_XBAR_MTIMER_SLAVE_IDX]     = in_window(master_req_i.addr, MTIMER_BASE);
        slave_hit[PERIPH_XBAR_LED_DRIVER_SLAVE_IDX] = in_window(master_req_i.addr, LED_BASE);
    end

    always_comb begin
        hit_idx = '0;
        for (int i = 0; i < PERIPH_XBAR_NUM_SLAVES; i++) begin
            if (slave_hit[i]) begin
                hit_idx = IDX_W'(i);
            end
        end
    end

    assign unmapped = ~|slave_hit;
    // stall is busy_q, so a new request only lands when idle
    assign accept   = master_req_i.cyc & master_req_i.stb & ~busy_q;

    // slaves only see a strobe for transfers the crossbar accepts
    always_comb begin
        for (int i = 0; i < PERIPH_XBAR_NUM_SLAVES; i++) begin
            slave_req_o[i]     = master_req_i;
            slave_req_o[i].stb = master_req_i.stb & slave_hit[i] & ~busy_q;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q <= 1'b0;
            err_q  <= 1'b0;
            sel_q  <= '0;
        end else if (accept) begin
            busy_q <= 1'b1;
            err_q  <= unmapped;
            sel_q  <= hit_idx;
        end else if (rsp_done) begin
            busy_q <= 1'b0;
            err_q  <= 1'b0;
        end
    end

    // route back the response of the slave picked at acceptance
    always_comb begin
        master_rsp_o = '0;
        if (busy_q && !err_q) begin
            master_rsp_o.ack   = slave_rsp_i[sel_q].ack;
            master_rsp_o.err   = slave_rsp_i[sel_q].err;
            master_rsp_o.rdata = slave_rsp_i[sel_q].rdata;
        end
        master_rsp_o.err   = master_rsp_o.err | err_q;
        master_rsp_o.stall = busy_q;
    end

    assign rsp_done = master_rsp_o.ack | master_rsp_o.err;

endmodule: periph_xbar

//--- mtimer_regs.sv
// machine timer register block on the peripheral bus
// mtimecmp storage with byte lane writes
// mtime word writes become load pulses toward the counter

module mtimer_regs (
    input  logic                     clk_i,
    input  logic                     rst_n_i,

    input  wb_pkg::wb_req_t          wb_req_i,
    output wb_pkg::wb_rsp_t          wb_rsp_o,

    input  logic [63:0]              mtime_i,
    output logic [63:0]              mtimecmp_o,
    output periph_pkg::mtimer_load_t load_o
);
    import wb_pkg::*;
    import periph_pkg::*;

    logic                        access;
    logic                        wr_en;
    logic [PERIPH_WINDOW_AW-1:0] offset;
    logic [PERIPH_WB_DW-1:0]     rd_word;
    logic [PERIPH_WB_DW-1:0]     rdata_q;
    logic                        ack_q;
    logic [63:0]                 mtimecmp_q;
    mtimer_load_t                load_q;

    // replace only the bytes flagged in sel
    function automatic logic [31:0] merge_lanes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  sel);
        logic [31:0] result;
        result = old_word;
        for (int i = 0; i < 4; i++) begin
            if (sel[i]) begin
                result[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return result;
    endfunction

    assign access = wb_req_i.cyc & wb_req_i.stb;
    assign wr_en  = access & wb_req_i.we;
    assign offset = {wb_req_i.addr[PERIPH_WINDOW_AW-1:2], 2'b00};

    always_comb begin
        case (offset)
            MTIMER_MTIME_LO:    rd_word = mtime_i[31:0];
            MTIMER_MTIME_HI:    rd_word = mtime_i[63:32];
            MTIMER_MTIMECMP_LO: rd_word = mtimecmp_q[31:0];
            MTIMER_MTIMECMP_HI: rd_word = mtimecmp_q[63:32];
            default:            rd_word = '0;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q      <= 1'b0;
            mtimecmp_q <= MTIMECMP_RESET;
            load_q     <= '0;
        end else begin
            ack_q          <= access;
            load_q.load_lo <= wr_en && (offset == MTIMER_MTIME_LO);
            load_q.load_hi <= wr_en && (offset == MTIMER_MTIME_HI);
            // untouched lanes keep the live counter bytes
            if (offset == MTIMER_MTIME_HI) begin
                load_q.value <= merge_lanes(mtime_i[63:32], wb_req_i.wdata, wb_req_i.sel);
            end else begin
                load_q.value <= merge_lanes(mtime_i[31:0], wb_req_i.wdata, wb_req_i.sel);
            end
            if (wr_en && (offset == MTIMER_MTIMECMP_LO)) begin
                mtimecmp_q[31:0] <= merge_lanes(mtimecmp_q[31:0], wb_req_i.wdata,
                                                wb_req_i.sel);
            end
            if (wr_en && (offset == MTIMER_MTIMECMP_HI)) begin
                mtimecmp_q[63:32] <= merge_lanes(mtimecmp_q[63:32], wb_req_i.wdata,
                                                 wb_req_i.sel);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (access && !wb_req_i.we) begin
            rdata_q <= rd_word;
        end
    end

    assign wb_rsp_o   = '{ack: ack_q, err: 1'b0, stall: 1'b0, rdata: rdata_q};
    assign mtimecmp_o = mtimecmp_q;
    assign load_o     = load_q;

endmodule: mtimer_regs

//--- mtimer_core.sv
// machine timer counter
// prescaled 64-bit mtime with word loads
// registered mtime >= mtimecmp compare as the timer interrupt

module mtimer_core #(
    parameter int unsigned MTIMER_DIV = 4
) (
    input  logic                     clk_i,
    input  logic                     rst_n_i,

    input  periph_pkg::mtimer_load_t load_i,
    input  logic [63:0]              mtimecmp_i,
    output logic [63:0]              mtime_o,
    output logic                     timer_irq_o
);
    import periph_pkg::*;

    localparam int unsigned DIV_W = (MTIMER_DIV > 1) ? $clog2(MTIMER_DIV) : 1;

    logic [DIV_W-1:0] div_cnt_q;
    logic [63:0]      mtime_q;
    logic             tick;
    logic             irq_q;

    assign tick = (div_cnt_q == DIV_W'(MTIMER_DIV - 1));

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            div_cnt_q <= '0;
            mtime_q   <= MTIME_RESET;
        end else if (load_i.load_lo || load_i.load_hi) begin
            // a software write restarts the prescaler
            div_cnt_q <= '0;
            if (load_i.load_lo) begin
                mtime_q[31:0] <= load_i.value;
            end
            if (load_i.load_hi) begin
                mtime_q[63:32] <= load_i.value;
            end
        end else if (tick) begin
            div_cnt_q <= '0;
            mtime_q   <= mtime_q + 64'd1;
        end else begin
            div_cnt_q <= div_cnt_q + 1'b1;
        end
    end

    // level interrupt, one cycle behind the compare
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            irq_q <= 1'b0;
        end else begin
            irq_q <= (mtime_q >= mtimecmp_i);
        end
    end

    assign mtime_o     = mtime_q;
    assign timer_irq_o = irq_q;

endmodule: mtimer_core

//--- led_driver.sv
// led status register on the peripheral bus
// write, set, clear and toggle access to one byte

module led_driver (
    input  logic            clk_i,
    input  logic            rst_n_i,

    input  wb_pkg::wb_req_t wb_req_i,
    output wb_pkg::wb_rsp_t wb_rsp_o,

    output logic [7:0]      led_status_o
);
    import wb_pkg::*;
    import periph_pkg::*;

    logic                        access;
    logic                        wr_en;
    logic [PERIPH_WINDOW_AW-1:0] offset;
    logic [7:0]                  wr_byte;
    logic [7:0]                  led_q;
    logic                        ack_q;
    logic [PERIPH_WB_DW-1:0]     rdata_q;

    assign access  = wb_req_i.cyc & wb_req_i.stb;
    // only the lowest byte lane carries led bits
    assign wr_en   = access & wb_req_i.we & wb_req_i.sel[0];
    assign offset  = {wb_req_i.addr[PERIPH_WINDOW_AW-1:2], 2'b00};
    assign wr_byte = wb_req_i.wdata[7:0];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            led_q <= LED_STATUS_RESET;
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
            if (wr_en) begin
                case (offset)
                    LED_STATUS: led_q <= wr_byte;
                    LED_SET:    led_q <= led_q | wr_byte;
                    LED_CLEAR:  led_q <= led_q & ~wr_byte;
                    LED_TOGGLE: led_q <= led_q ^ wr_byte;
                    default:    led_q <= led_q;
                endcase
            end
        end
    end

    // any offset reads back the current byte
    always_ff @(posedge clk_i) begin
        if (access && !wb_req_i.we) begin
            rdata_q <= {{(PERIPH_WB_DW-8){1'b0}}, led_q};
        end
    end

    assign wb_rsp_o     = '{ack: ack_q, err: 1'b0, stall: 1'b0, rdata: rdata_q};
    assign led_status_o = led_q;

endmodule: led_driver

//--- periph_subsys.sv
// peripheral subsystem top level
// crossbar, machine timer and led driver

module periph_subsys #(
    parameter int unsigned MTIMER_DIV = 4
) (
    input  logic            clk_i,
    input  logic            rst_n_i,

    input  wb_pkg::wb_req_t wb_req_i,
    output wb_pkg::wb_rsp_t wb_rsp_o,

    output logic [7:0]      led_status_o,
    output logic            timer_irq_o
);
    import wb_pkg::*;
    import periph_pkg::*;

    wb_req_t      slave_req [PERIPH_XBAR_NUM_SLAVES];
    wb_rsp_t      slave_rsp [PERIPH_XBAR_NUM_SLAVES];
    logic [63:0]  mtime;
    logic [63:0]  mtimecmp;
    mtimer_load_t mtimer_load;

    periph_xbar u_periph_xbar (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .master_req_i (wb_req_i),
        .master_rsp_o (wb_rsp_o),
        .slave_req_o  (slave_req),
        .slave_rsp_i  (slave_rsp)
    );

    // timer register block and counter
    mtimer_regs u_mtimer_regs (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .wb_req_i   (slave_req[PERIPH_XBAR_MTIMER_SLAVE_IDX]),
        .wb_rsp_o   (slave_rsp[PERIPH_XBAR_MTIMER_SLAVE_IDX]),
        .mtime_i    (mtime),
        .mtimecmp_o (mtimecmp),
        .load_o     (mtimer_load)
    );

    mtimer_core #(
        .MTIMER_DIV (MTIMER_DIV)
    ) u_mtimer_core (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .load_i      (mtimer_load),
        .mtimecmp_i  (mtimecmp),
        .mtime_o     (mtime),
        .timer_irq_o (timer_irq_o)
    );

    led_driver u_led_driver (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .wb_req_i     (slave_req[PERIPH_XBAR_LED_DRIVER_SLAVE_IDX]),
        .wb_rsp_o     (slave_rsp[PERIPH_XBAR_LED_DRIVER_SLAVE_IDX]),
        .led_status_o (led_status_o)
    );

endmodule: periph_subsys

//--- tb_periph_subsys.sv
// testbench for the peripheral subsystem
// replays bus operations from periph_stim.txt
// checks read data, bus timing, led outputs and the timer interrupt

module tb_periph_subsys;
    timeunit 1ns;
    timeprecision 1ps;

    import wb_pkg::*;
    import periph_pkg::*;

    localparam int unsigned MTIMER_DIV  = 4;
    localparam int unsigned RSP_TIMEOUT = 10;

    logic        clk_i;
    logic        rst_n_i;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    logic [7:0]  led_status;
    logic        timer_irq;

    int          pass_cnt;
    int          fail_cnt;
    int          cycle_cnt;
    int          last_wr_cycle;
    bit          line_ok;

    // response captured in the ack or err cycle
    logic        got_ack;
    logic        got_err;
    logic [31:0] got_rdata;

    periph_subsys #(
        .MTIMER_DIV (MTIMER_DIV)
    ) u_periph_subsys (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .wb_req_i     (wb_req),
        .wb_rsp_o     (wb_rsp),
        .led_status_o (led_status),
        .timer_irq_o  (timer_irq)
    );

    always #50 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("CHECK FAILED at %0d ns: %s expected %h, got %h", $time, name, exp, act);
        line_ok = 1'b0;
    endtask

    task automatic report_problem(input string what);
        $display("at %0d ns: %s", $time, what);
        line_ok = 1'b0;
    endtask

    // one transfer, called 1 ns after a rising edge and left 1 ns after one
    task automatic bus_access(input logic we, input logic [31:0] addr,
                              input logic [31:0] wdata, input logic [3:0] sel);
        int waited;
        got_ack   = 1'b0;
        got_err   = 1'b0;
        got_rdata = '0;
        wb_req    = '{cyc: 1'b1, stb: 1'b1, we: we, addr: addr, wdata: wdata, sel: sel};
        waited    = 0;
        @(negedge clk_i);
        while (wb_rsp.stall && waited < RSP_TIMEOUT) begin
            @(negedge clk_i);
            waited++;
        end
        if (wb_rsp.stall) begin
            report_problem("the crossbar never accepted the request");
            @(posedge clk_i);
            #1 wb_req = '0;
            return;
        end
        // accepted at the coming edge
        @(posedge clk_i);
        #1 wb_req.stb = 1'b0;
        waited = 0;
        @(negedge clk_i);
        while (!(wb_rsp.ack || wb_rsp.err) && waited < RSP_TIMEOUT) begin
            if (!wb_rsp.stall) begin
                report_problem("stall dropped before the response arrived");
            end
            @(negedge clk_i);
            waited++;
        end
        got_ack   = wb_rsp.ack;
        got_err   = wb_rsp.err;
        got_rdata = wb_rsp.rdata;
        if (!(got_ack || got_err)) begin
            report_problem("no ack or err arrived after the request was accepted");
        end else if (waited != 0) begin
            report_problem($sformatf("response came %0d cycles late", waited));
        end
        if (!wb_rsp.stall) begin
            report_mismatch("stall", 32'h1, 32'h0);
        end
        @(posedge clk_i);
        #1 wb_req = '0;
        // ack and err last a single cycle
        if (wb_rsp.ack || wb_rsp.err) begin
            report_problem("ack or err stayed high for more than one cycle");
        end
    endtask

    task automatic run_op(input byte op, input logic [31:0] addr, input logic [31:0] wdata,
                          input logic [3:0] sel, input logic [31:0] exp);
        int          waited;
        int          limit;
        int          elapsed;
        logic [31:0] upper;
        case (op)
            "W": begin
                bus_access(1'b1, addr, wdata, sel);
                if (!got_ack || got_err) begin
                    report_problem("write was not acknowledged");
                end
                last_wr_cycle = cycle_cnt;
            end
            "R", "E": begin
                bus_access(1'b0, addr, 32'h0, sel);
                if (op == "E") begin
                    if (!got_err) begin
                        report_mismatch("err", 32'h1, {31'h0, got_err});
                    end
                    if (got_ack) begin
                        report_mismatch("ack", 32'h0, {31'h0, got_ack});
                    end
                end else if (!got_ack || got_err) begin
                    report_problem("read was not acknowledged");
                end
                if (got_rdata !== exp) begin
                    report_mismatch("rdata", exp, got_rdata);
                end
                // led window reads must agree with the output pins
                if (op == "R" && addr[31:PERIPH_WINDOW_AW] == LED_BASE[31:PERIPH_WINDOW_AW]) begin
                    if (led_status !== exp[7:0]) begin
                        report_mismatch("led_status_o", exp, {24'h0, led_status});
                    end
                end
            end
            "I": begin
                limit  = exp[0] ? 40 * MTIMER_DIV : 3;
                waited = 0;
                @(negedge clk_i);
                while (timer_irq !== exp[0] && waited < limit) begin
                    @(negedge clk_i);
                    waited++;
                end
                if (timer_irq !== exp[0]) begin
                    report_problem($sformatf("timer_irq_o did not reach %0b within %0d cycles",
                                             exp[0], limit));
                end
                @(posedge clk_i);
                #1;
            end
            "T": begin
                bus_access(1'b0, addr, 32'h0, sel);
                elapsed = cycle_cnt - last_wr_cycle;
                upper   = wdata + 32'(elapsed / MTIMER_DIV) + 32'd1;
                if (got_rdata < wdata || got_rdata > upper) begin
                    $display("CHECK FAILED at %0d ns: mtime_lo expected %h..%h, got %h",
                             $time, wdata, upper, got_rdata);
                    line_ok = 1'b0;
                end
            end
            default: begin
                report_problem($sformatf("unknown op letter %c in the stim file", op));
            end
        endcase
    endtask

    initial begin
        int          fd;
        int          n;
        int          line_no;
        string       line;
        byte         op;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  sel;
        logic [31:0] exp;
        clk_i         = 1'b0;
        rst_n_i       = 1'b0;
        wb_req        = '0;
        pass_cnt      = 0;
        fail_cnt      = 0;
        cycle_cnt     = 0;
        last_wr_cycle = 0;
        line_no       = 0;
        repeat (5) @(posedge clk_i);
        #1 rst_n_i = 1'b1;
        fd = $fopen("periph_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open periph_stim.txt");
            fail_cnt++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                n = $sscanf(line, " %c %h %h %h %h", op, addr, wdata, sel, exp);
                if (n == 5 && op != "#") begin
                    line_no++;
                    line_ok = 1'b1;
                    run_op(op, addr, wdata, sel, exp);
                    if (line_ok) begin
                        pass_cnt++;
                        $display("stim line %0d (%c %h) passed", line_no, op, addr);
                    end else begin
                        fail_cnt++;
                        $display("stim line %0d (%c %h) failed", line_no, op, addr);
                    end
                end
            end
            $fclose(fd);
        end
        $display("%0d passed, %0d failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && pass_cnt > 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule: tb_periph_subsys

//--- periph_stim.txt
# columns: op addr wdata sel expected, all hex
# ops: W write, R read, E err, I irq level, T mtime_lo window
I 00000000 00000000 f 00000000
W 00001000 0000005a f 00000000
R 00001000 00000000 f 0000005a
W 00001004 00000081 f 00000000
R 00001004 00000000 f 000000db
W 00001008 0000000a f 00000000
R 00001008 00000000 f 000000d1
W 0000100c 000000ff f 00000000
R 0000100c 00000000 f 0000002e
W 00000008 11223344 f 00000000
R 00000008 00000000 f 11223344
W 00000008 aabbccdd 3 00000000
R 00000008 00000000 f 1122ccdd
W 0000000c 55667788 f 00000000
R 0000000c 00000000 f 55667788
W 00000000 00001000 f 00000000
T 00000000 00001000 f 00000000
E 00002000 00000000 f 00000000
W 00000000 00000000 f 00000000
W 00000004 00000000 f 00000000
W 00000008 00000014 f 00000000
W 0000000c 00000000 f 00000000
I 00000000 00000000 f 00000001
W 0000000c ffffffff f 00000000
I 00000000 00000000 f 00000000

//--- flist.f
wb_pkg.sv
periph_pkg.sv
periph_xbar.sv
mtimer_regs.sv
mtimer_core.sv
led_driver.sv
periph_subsys.sv
tb_periph_subsys.sv

//--- Bender.yml
package:
  name: periph_subsys

sources:
  - wb_pkg.sv
  - periph_pkg.sv
  - periph_xbar.sv
  - mtimer_regs.sv
  - mtimer_core.sv
  - led_driver.sv
  - periph_subsys.sv
  - target: test
    files:
      - tb_periph_subsys.sv
